/* tb.f */
source/an_pkg.sv
source/an_link_timer.sv
source/an_rx_match.sv
source/an_arbitration.sv
source/an_tx_ordered_set.sv
source/an_top.sv
dv/an_tb.sv

/* dv/an_tb.sv */
// Testbench for an_top with a 32-cycle link timer; partner values come from a fixed-seed LCG
`timescale 1ns/1ps
module an_tb import an_pkg::*; ();
  localparam int          TIMER_CYCLES = 32;
  localparam logic [15:0] ADV_ABILITY  = 16'h0020;
  localparam logic [15:0] ACK_MASK     = 16'(1) << ACK_BIT;
  localparam int          NUM_TESTS    = 6;
  localparam int          TIMEOUT_NS   = NUM_TESTS * 40 * TIMER_CYCLES * 10;
  // Negotiation phases for the expected transmitted config
  localparam int PH_RESTART = 0;
  localparam int PH_ABILITY = 1;
  localparam int PH_ACK     = 2;
  // Link partner modes
  localparam int MODE_NONE   = 0;
  localparam int MODE_CONFIG = 1;
  localparam int MODE_IDLE   = 2;

  logic        clk;
  logic        mr_main_reset;
  code_group_t rx;
  logic        los;
  code_group_t tx;
  logic        negotiating;
  logic [15:0] lacr_rx_val;

  int          partner_mode = MODE_NONE;
  logic [15:0] partner_cfg  = '0;
  logic [31:0] lcg_state    = 32'd29;
  // Monitor view of the transmitted ordered sets
  logic [15:0] cfg_val      = '0;
  code_group_t cfg_id       = '0;
  int          cfg_sets     = 0;
  code_group_t idle_id      = '0;
  int          idle_sets    = 0;
  logic        neg_low_seen = 1'b0;
  int          mon_pos      = 0;
  logic [7:0]  mon_low;
  string       test_name;
  int          errors = 0;
  int          errors_before;
  int          tests_passed = 0;
  int          tests_failed = 0;

  an_top #(
    .LINK_TIMER_CYCLES (TIMER_CYCLES),
    .ADV_ABILITY       (ADV_ABILITY)
  ) an_top_inst (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .rx            (rx),
    .los           (los),
    .tx            (tx),
    .negotiating   (negotiating),
    .lacr_rx_val   (lacr_rx_val)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  // Transmitted config register expected in each phase
  function automatic logic [15:0] expected_config(int phase);
    case (phase)
      PH_RESTART: return 16'h0000;
      PH_ABILITY: return ADV_ABILITY;
      default:    return ADV_ABILITY | ACK_MASK;
    endcase
  endfunction

  // Second code group of the set that follows one carrying g
  function automatic code_group_t next_second_group(code_group_t g);
    case (g.data)
      D21_5:   return '{is_k: 1'b0, data: D2_2};
      D2_2:    return '{is_k: 1'b0, data: D21_5};
      D5_6:    return '{is_k: 1'b0, data: D16_2};
      default: return '{is_k: 1'b0, data: D5_6};
    endcase
  endfunction

  task automatic check_config(input logic [15:0] expected, input logic [15:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_code_group(input code_group_t expected, input code_group_t actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected k=%b %h, actual k=%b %h", test_name,
               expected.is_k, expected.data, actual.is_k, actual.data);
      errors++;
    end
  endtask

  task automatic check_flag(input bit expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %b, actual %b", test_name, expected, actual);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    errors_before = errors;
  endtask

  task automatic finish_test();
    if (errors == errors_before) begin
      tests_passed++;
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - errors_before);
    end
  endtask

  task automatic send_group(input logic is_k, input logic [7:0] data);
    @(negedge clk);
    rx = '{is_k: is_k, data: data};
  endtask

  // Link partner, one ordered set per loop
  initial begin
    logic [15:0] value;
    logic        alt;
    alt = 1'b0;
    forever begin
      value = partner_cfg;
      case (partner_mode)
        MODE_CONFIG: begin
          send_group(1'b1, K28_5);
          send_group(1'b0, alt ? D2_2 : D21_5);
          send_group(1'b0, value[7:0]);
          send_group(1'b0, value[15:8]);
        end
        MODE_IDLE: begin
          send_group(1'b1, K28_5);
          send_group(1'b0, alt ? D16_2 : D5_6);
        end
        default: send_group(1'b0, 8'h00);
      endcase
      alt = ~alt;
    end
  end

  // Parse tx into config and idle sets
  always @(negedge clk) begin
    if (negotiating === 1'b0) neg_low_seen = 1'b1;
    if (tx.is_k && tx.data == K28_5) begin
      mon_pos = 1;
    end else begin
      case (mon_pos)
        1: begin
          if (!tx.is_k && (tx.data == D21_5 || tx.data == D2_2)) begin
            cfg_id  = tx;
            mon_pos = 2;
          end else if (!tx.is_k && (tx.data == D5_6 || tx.data == D16_2)) begin
            idle_id = tx;
            idle_sets++;
            mon_pos = 0;
          end else begin
            mon_pos = 0;
          end
        end
        2: begin
          mon_low = tx.data;
          mon_pos = 3;
        end
        3: begin
          cfg_val = {tx.data, mon_low};
          cfg_sets++;
          mon_pos = 0;
        end
        default: mon_pos = 0;
      endcase
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired before all tests finished");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    int          n;
    int          i;
    logic [15:0] partner_value;
    code_group_t first_id;
    mr_main_reset = 1'b1;
    rx            = '0;
    los           = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    mr_main_reset = 1'b0;

    start_test("reset_config");
    n = cfg_sets;
    wait (cfg_sets > n);
    first_id = cfg_id;
    check_config(expected_config(PH_RESTART), cfg_val);
    wait (cfg_sets > n + 1);
    check_config(expected_config(PH_RESTART), cfg_val);
    check_code_group(next_second_group(first_id), cfg_id);
    check_flag(1'b1, negotiating);
    finish_test();

    start_test("ability_exchange");
    partner_value = (next_random() & ~ACK_MASK) | 16'h0001;
    partner_cfg   = partner_value;
    partner_mode  = MODE_CONFIG;
    wait (cfg_val != expected_config(PH_RESTART));
    check_config(expected_config(PH_ABILITY), cfg_val);
    wait (cfg_val != expected_config(PH_ABILITY));
    check_config(expected_config(PH_ACK), cfg_val);
    check_config(partner_value, lacr_rx_val);
    finish_test();

    start_test("link_up");
    partner_cfg = partner_value | ACK_MASK;
    n = idle_sets;
    wait (idle_sets > n);
    partner_mode = MODE_IDLE;
    first_id = idle_id;
    wait (idle_sets > n + 1);
    check_code_group(next_second_group(first_id), idle_id);
    wait (negotiating == 1'b0);
    @(negedge clk);
    @(negedge clk);
    check_code_group('0, tx);
    check_flag(1'b0, negotiating);
    finish_test();

    start_test("breaklink");
    partner_cfg  = 16'h0000;
    partner_mode = MODE_CONFIG;
    wait (negotiating == 1'b1);
    n = cfg_sets;
    wait (cfg_sets > n);
    check_config(expected_config(PH_RESTART), cfg_val);
    finish_test();

    start_test("inconsistent_ack");
    partner_value = (next_random() & ~ACK_MASK) | 16'h0001;
    partner_cfg   = partner_value;
    neg_low_seen  = 1'b0;
    wait (cfg_val == expected_config(PH_ACK));
    partner_cfg = (partner_value ^ 16'h0100) | ACK_MASK;
    wait (cfg_val != expected_config(PH_ACK));
    check_config(expected_config(PH_RESTART), cfg_val);
    check_flag(1'b0, neg_low_seen);
    finish_test();

    start_test("loss_of_signal");
    @(negedge clk);
    los = 1'b1;
    repeat (3) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      check_code_group('0, tx);
      check_flag(1'b1, negotiating);
      @(negedge clk);
    end
    finish_test();

    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             NUM_TESTS, tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* source/an_top.sv */
// Auto-negotiation top; default timer length assumes 10 ms at a 125 MHz clock
`timescale 1ns/1ps
module an_top import an_pkg::*; #(
  parameter int          LINK_TIMER_CYCLES = 1250000,
  parameter logic [15:0] ADV_ABILITY       = 16'h0020
) (
  input  logic        clk,
  input  logic        mr_main_reset,
  input  code_group_t rx,
  input  logic        los,
  output code_group_t tx,
  output logic        negotiating,
  output logic [15:0] lacr_rx_val
);
  match_status_t status;
  match_ctrl_t   ctrl;
  logic          timer_start;
  logic          timer_running;
  logic          timer_done;
  xmit_e         xmit;
  logic          xmit_restart;
  logic [15:0]   tx_config;

  assign lacr_rx_val = status.rx_config;

  an_rx_match an_rx_match_inst (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .rx            (rx),
    .ctrl          (ctrl),
    .status        (status)
  );

  an_arbitration #(
    .ADV_ABILITY (ADV_ABILITY)
  ) an_arbitration_inst (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .los           (los),
    .status        (status),
    .timer_running (timer_running),
    .timer_done    (timer_done),
    .ctrl          (ctrl),
    .timer_start   (timer_start),
    .xmit          (xmit),
    .xmit_restart  (xmit_restart),
    .tx_config     (tx_config),
    .negotiating   (negotiating)
  );

  an_link_timer #(
    .CYCLES (LINK_TIMER_CYCLES)
  ) an_link_timer_inst (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .start         (timer_start),
    .running       (timer_running),
    .done          (timer_done)
  );

  an_tx_ordered_set an_tx_ordered_set_inst (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .xmit          (xmit),
    .xmit_restart  (xmit_restart),
    .tx_config     (tx_config),
    .tx            (tx)
  );

endmodule

/* source/an_tx_ordered_set.sv */
// Transmit generator at full rate; tx_config is sampled byte by byte as it goes out
`timescale 1ns/1ps
module an_tx_ordered_set import an_pkg::*; (
  input  logic        clk,
  input  logic        mr_main_reset,
  input  xmit_e       xmit,
  input  logic        xmit_restart,
  input  logic [15:0] tx_config,
  output code_group_t tx
);
  logic [1:0] pos;
  logic [1:0] pos_cur;
  logic       alt;
  logic       alt_cur;

  // Restart takes effect on the group sent this cycle
  assign pos_cur = xmit_restart ? 2'd0 : pos;
  assign alt_cur = xmit_restart ? 1'b0 : alt;

  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      tx  <= '0;
      pos <= '0;
      alt <= 1'b0;
    end else begin
      case (xmit)
        XMIT_CONFIGURATION: begin
          // C1 carries D21.5, C2 carries D2.2
          case (pos_cur)
            2'd0: tx <= '{is_k: 1'b1, data: K28_5};
            2'd1: tx <= '{is_k: 1'b0, data: alt_cur ? D2_2 : D21_5};
            2'd2: tx <= '{is_k: 1'b0, data: tx_config[7:0]};
            default: tx <= '{is_k: 1'b0, data: tx_config[15:8]};
          endcase
          pos <= pos_cur + 2'd1;
          alt <= (pos_cur == 2'd3) ? ~alt_cur : alt_cur;
        end
        XMIT_IDLE: begin
          // I1 then I2, two groups each
          if (pos_cur[0]) tx <= '{is_k: 1'b0, data: alt_cur ? D16_2 : D5_6};
          else tx <= '{is_k: 1'b1, data: K28_5};
          pos <= {1'b0, ~pos_cur[0]};
          alt <= pos_cur[0] ? ~alt_cur : alt_cur;
        end
        default: begin
          tx  <= '0;
          pos <= pos_cur;
          alt <= alt_cur;
        end
      endcase
    end
  end

endmodule

/* source/an_arbitration.sv */
// Clause 37 arbitration without next page; auto-negotiation is always enabled
`timescale 1ns/1ps
module an_arbitration import an_pkg::*; #(
  parameter logic [15:0] ADV_ABILITY = 16'h0020
) (
  input  logic          clk,
  input  logic          mr_main_reset,
  input  logic          los,
  input  match_status_t status,
  input  logic          timer_running,
  input  logic          timer_done,
  output match_ctrl_t   ctrl,
  output logic          timer_start,
  output xmit_e         xmit,
  output logic          xmit_restart,
  output logic [15:0]   tx_config,
  output logic          negotiating
);
  an_state_e state;
  an_state_e state_next;
  logic      breaklink;
  logic      timed_state;
  logic      timer_armed;
  logic      timer_expired;

  // A zero config seen as an ability match is the partner's breaklink
  assign breaklink   = status.ability_match && (status.rx_config == '0);
  assign timed_state = state inside {AN_RESTART, COMPLETE_ACKNOWLEDGE, IDLE_DETECT};
  assign negotiating = state != LINK_OK;

  // Matches are cleared on the transition edge itself
  always_comb begin
    ctrl.clear = (state_next != state) && (state != ACKNOWLEDGE_DETECT);
    ctrl.capture_consistency = state inside {ABILITY_DETECT, ABILITY_DETECT_WAIT};
  end

  always_comb begin
    state_next = state;
    if (los) begin
      state_next = AN_DISABLE_LINK_OK;
    end else begin
      case (state)
        AN_ENABLE: state_next = AN_RESTART;
        AN_RESTART: begin
          if (timer_expired) state_next = ABILITY_DETECT;
        end
        AN_DISABLE_LINK_OK: state_next = AN_ENABLE;
        ABILITY_DETECT: state_next = ABILITY_DETECT_WAIT;
        ABILITY_DETECT_WAIT: begin
          if (status.ability_match) begin
            state_next = breaklink ? AN_ENABLE : ACKNOWLEDGE_DETECT;
          end
        end
        ACKNOWLEDGE_DETECT: state_next = ACKNOWLEDGE_DETECT_WAIT;
        ACKNOWLEDGE_DETECT_WAIT: begin
          if (breaklink || (status.acknowledge_match && !status.consistency_match)) begin
            state_next = AN_ENABLE;
          end else if (status.acknowledge_match) begin
            state_next = COMPLETE_ACKNOWLEDGE;
          end
        end
        COMPLETE_ACKNOWLEDGE: begin
          if (breaklink) state_next = AN_ENABLE;
          else if (timer_expired) state_next = IDLE_DETECT;
        end
        IDLE_DETECT: begin
          if (breaklink) state_next = AN_ENABLE;
          else if (timer_expired && status.idle_match) state_next = LINK_OK;
        end
        LINK_OK: begin
          if (status.ability_match) state_next = AN_ENABLE;
        end
        default: state_next = AN_ENABLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      state         <= AN_ENABLE;
      xmit          <= XMIT_IDLE;
      xmit_restart  <= 1'b0;
      tx_config     <= '0;
      timer_start   <= 1'b0;
      timer_armed   <= 1'b0;
      timer_expired <= 1'b0;
    end else begin
      state        <= state_next;
      xmit_restart <= 1'b0;
      timer_start  <= 1'b0;
      if (state_next != state) begin
        timer_armed   <= 1'b0;
        timer_expired <= 1'b0;
        // Outputs change on entry to the new state
        case (state_next)
          AN_RESTART: begin
            tx_config    <= '0;
            xmit         <= XMIT_CONFIGURATION;
            xmit_restart <= 1'b1;
          end
          AN_DISABLE_LINK_OK: xmit <= XMIT_DATA;
          ABILITY_DETECT: tx_config <= ADV_ABILITY;
          ACKNOWLEDGE_DETECT: tx_config[ACK_BIT] <= 1'b1;
          IDLE_DETECT: begin
            xmit         <= XMIT_IDLE;
            xmit_restart <= 1'b1;
          end
          LINK_OK: begin
            xmit         <= XMIT_DATA;
            xmit_restart <= 1'b1;
          end
          default: begin
          end
        endcase
      end else if (timed_state && !timer_armed && !timer_running) begin
        // A period left over from an aborted state must end first
        timer_start <= 1'b1;
        timer_armed <= 1'b1;
      end else if (timer_armed && timer_done) begin
        timer_expired <= 1'b1;
      end
    end
  end

  state_legal: assert property (@(posedge clk) disable iff (mr_main_reset)
    state inside {[AN_ENABLE:LINK_OK]});

endmodule

/* source/an_rx_match.sv */
// Receive matcher; expects aligned code groups, next-page pages are not tracked
`timescale 1ns/1ps
module an_rx_match import an_pkg::*; (
  input  logic          clk,
  input  logic          mr_main_reset,
  input  code_group_t   rx,
  input  match_ctrl_t   ctrl,
  output match_status_t status
);
  typedef enum logic [1:0] {
    DEC_HUNT,
    DEC_GOT_K,
    DEC_CR_LOW,
    DEC_CR_HIGH
  } dec_state_e;

  localparam logic [15:0] ACK_MASK = 16'(1) << ACK_BIT;

  code_group_t rx_q;
  dec_state_e  dec_state;
  logic [7:0]  cr_low;
  logic [15:0] rx_config;
  logic [15:0] rx_last;
  logic [15:0] rx_snapshot;
  logic        cfg_stb;
  logic        idle_stb;
  logic        is_k28_5;
  logic        is_cfg_id;
  logic        is_idle_id;
  logic        ability_agree;
  logic        ack_agree;
  logic        ability_match;
  logic        acknowledge_match;
  logic        consistency_match;
  logic        idle_match;
  logic [1:0]  ability_cnt;
  logic [1:0]  ack_cnt;
  logic [1:0]  idle_cnt;

  assign is_k28_5   = rx_q.is_k && (rx_q.data == K28_5);
  assign is_cfg_id  = !rx_q.is_k && (rx_q.data == D21_5 || rx_q.data == D2_2);
  assign is_idle_id = !rx_q.is_k && (rx_q.data == D5_6 || rx_q.data == D16_2);

  // Newest register against the previous one, acknowledge bit ignored or not
  assign ability_agree = ((rx_config ^ rx_last) & ~ACK_MASK) == '0;
  assign ack_agree     = rx_config[ACK_BIT] && (rx_config == rx_last);

  // Ordered-set decoder
  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      rx_q        <= '0;
      dec_state   <= DEC_HUNT;
      cfg_stb     <= 1'b0;
      idle_stb    <= 1'b0;
      rx_config   <= '0;
      rx_last     <= '0;
      rx_snapshot <= '0;
    end else begin
      rx_q     <= rx;
      cfg_stb  <= 1'b0;
      idle_stb <= 1'b0;
      case (dec_state)
        DEC_HUNT: begin
          if (is_k28_5) dec_state <= DEC_GOT_K;
        end
        DEC_GOT_K: begin
          if (is_cfg_id) begin
            dec_state <= DEC_CR_LOW;
          end else begin
            idle_stb  <= is_idle_id;
            dec_state <= is_k28_5 ? DEC_GOT_K : DEC_HUNT;
          end
        end
        DEC_CR_LOW: dec_state <= DEC_CR_HIGH;
        default: begin
          rx_config <= {rx_q.data, cr_low};
          cfg_stb   <= 1'b1;
          dec_state <= DEC_HUNT;
        end
      endcase
      if (cfg_stb) begin
        rx_last <= rx_config;
        if (ctrl.capture_consistency) rx_snapshot <= rx_config;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dec_state == DEC_CR_LOW) cr_low <= rx_q.data;
  end

  // Match counters, held once a match is found until the next clear
  always_ff @(posedge clk) begin
    if (mr_main_reset || ctrl.clear) begin
      ability_match     <= 1'b0;
      acknowledge_match <= 1'b0;
      consistency_match <= 1'b0;
      idle_match        <= 1'b0;
      ability_cnt       <= '0;
      ack_cnt           <= '0;
      idle_cnt          <= '0;
    end else begin
      if (idle_stb && !idle_match) begin
        if (idle_cnt == 2'd2) idle_match <= 1'b1;
        else idle_cnt <= idle_cnt + 2'd1;
      end
      if (cfg_stb && !ability_match) begin
        if (!ability_agree) ability_cnt <= '0;
        else if (ability_cnt == 2'd2) ability_match <= 1'b1;
        else ability_cnt <= ability_cnt + 2'd1;
      end
      if (cfg_stb && !acknowledge_match) begin
        if (!ack_agree) begin
          ack_cnt <= '0;
        end else if (ack_cnt == 2'd2) begin
          acknowledge_match <= 1'b1;
          // Same abilities as seen during ability detect
          consistency_match <= ((rx_config ^ rx_snapshot) & ~ACK_MASK) == '0;
        end else begin
          ack_cnt <= ack_cnt + 2'd1;
        end
      end
    end
  end

  assign status = '{
    ability_match:     ability_match,
    acknowledge_match: acknowledge_match,
    consistency_match: consistency_match,
    idle_match:        idle_match,
    rx_config:         rx_config
  };

  ack_needs_ack_bit: assert property (@(posedge clk) disable iff (mr_main_reset)
    $rose(acknowledge_match) |-> rx_config[ACK_BIT]);

endmodule

/* source/an_link_timer.sv */
// One-shot timer; done lasts one cycle, and a start while running is not supported
`timescale 1ns/1ps
module an_link_timer #(
  parameter int CYCLES = 1250000
) (
  input  logic clk,
  input  logic mr_main_reset,
  input  logic start,
  output logic running,
  output logic done
);
  localparam int CW = (CYCLES > 1) ? $clog2(CYCLES) : 1;

  logic [CW-1:0] count;
  logic          last;

  assign last = count == CW'(CYCLES - 1);
  assign done = running && last;

  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      running <= 1'b0;
      count   <= '0;
    end else if (start) begin
      running <= 1'b1;
      count   <= '0;
    end else if (running) begin
      // Stop on the terminal count, done is seen for that one cycle
      if (last) begin
        running <= 1'b0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // Arbitration must wait for the previous period to end
  start_when_idle: assert property (@(posedge clk) disable iff (mr_main_reset)
    start |-> !running);

endmodule

/* source/an_pkg.sv */
// Shared clause 37 definitions; code groups are already 8b/10b decoded, one per clock
package an_pkg;

  // One decoded code group, K flag plus byte
  typedef struct packed {
    logic       is_k;
    logic [7:0] data;
  } code_group_t;

  localparam logic [7:0] K28_5 = 8'hbc;
  localparam logic [7:0] D21_5 = 8'hb5;
  localparam logic [7:0] D2_2  = 8'h42;
  localparam logic [7:0] D5_6  = 8'hc5;
  localparam logic [7:0] D16_2 = 8'h50;

  // Acknowledge bit position in a config register
  localparam int ACK_BIT = 14;

  typedef enum logic [1:0] {
    XMIT_IDLE,
    XMIT_CONFIGURATION,
    XMIT_DATA
  } xmit_e;

  typedef enum logic [3:0] {
    AN_ENABLE,
    AN_RESTART,
    AN_DISABLE_LINK_OK,
    ABILITY_DETECT,
    ABILITY_DETECT_WAIT,
    ACKNOWLEDGE_DETECT,
    ACKNOWLEDGE_DETECT_WAIT,
    COMPLETE_ACKNOWLEDGE,
    IDLE_DETECT,
    LINK_OK
  } an_state_e;

  typedef struct packed {
    logic        ability_match;
    logic        acknowledge_match;
    logic        consistency_match;
    logic        idle_match;
    logic [15:0] rx_config;
  } match_status_t;

  typedef struct packed {
    logic clear;
    logic capture_consistency;
  } match_ctrl_t;

endpackage
